// ==== include/spi_pu_macros.svh ====
`ifndef SPI_PU_MACROS_SVH
`define SPI_PU_MACROS_SVH

// System word and SPI byte widths
`define SPI_PU_DATA_WIDTH 32
`define SPI_PU_BYTE_WIDTH 8

// Buffer depths in words
`define SPI_PU_TX_DEPTH 4
`define SPI_PU_RX_DEPTH 4

// Wishbone word offsets
`define SPI_PU_ADR_DATA   0
`define SPI_PU_ADR_STATUS 1

`endif

// ==== source/spi_pu_pkg.sv ====
`include "spi_pu_macros.svh"

package spi_pu_pkg;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                          cyc;
    logic                          stb;
    logic                          we;
    logic [3:0]                    adr;
    logic [`SPI_PU_DATA_WIDTH-1:0] dat;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic [`SPI_PU_DATA_WIDTH-1:0] dat;
    logic                          ack;
    logic                          err;
  } wb_rsp_t;

  // SPI pins driven by the external master
  typedef struct packed {
    logic sclk;
    logic mosi;
    logic cs;
  } spi_in_t;

  typedef struct packed {
    logic [`SPI_PU_DATA_WIDTH-1:0] data;
  } tx_word_t;

  // Last marks the final complete word of a frame
  typedef struct packed {
    logic [`SPI_PU_DATA_WIDTH-1:0] data;
    logic                          last;
  } rx_entry_t;

  typedef struct packed {
    logic [`SPI_PU_DATA_WIDTH-12:0] rsvd;
    logic [2:0]                     rx_count;
    logic [2:0]                     fill_count;
    logic [2:0]                     drain_count;
    logic                           fill_bank;
    logic                           in_frame;
  } status_t;

endpackage

// ==== source/word_buffer.sv ====
module word_buffer #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  output logic       in_ready,
  input  payload_t   in_data,
  output logic       out_valid,
  input  logic       out_ready,
  output payload_t   out_data,
  input  logic       flush,
  output logic [2:0] count
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    next_ptr = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + AW'(1);
  endfunction

  assign in_ready  = (count < 3'(DEPTH));
  assign out_valid = (count != 3'd0);
  assign out_data  = mem[rd_ptr];
  assign do_push   = in_valid && in_ready && !flush;
  assign do_pop    = out_valid && out_ready && !flush;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 3'd1;
        2'b01:   count <= count - 3'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= in_data;
  end

  // A full buffer keeps its contents until a pop frees a slot
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    (count == 3'(DEPTH) && !do_pop && !flush) |=> (count == 3'(DEPTH) && $stable(wr_ptr)));

  // Read side stays put while empty
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    (count == 3'd0 && !flush) |=> $stable(rd_ptr));

endmodule

// ==== source/spi_slave_driver.sv ====
`include "spi_pu_macros.svh"

module spi_slave_driver (
  input  logic                          clk,
  input  logic                          rst,
  input  spi_pu_pkg::spi_in_t           spi,
  input  logic [`SPI_PU_BYTE_WIDTH-1:0] tx_byte,
  output logic                          miso,
  output logic [`SPI_PU_BYTE_WIDTH-1:0] rx_byte,
  output logic                          rx_byte_valid,
  output logic                          byte_done,
  output logic                          frame_begin,
  output logic                          frame_end,
  output logic                          in_frame
);

  import spi_pu_pkg::*;

  localparam int BW = `SPI_PU_BYTE_WIDTH;
  localparam int CW = $clog2(BW);

  spi_in_t       sync_a;
  spi_in_t       sync_b;
  spi_in_t       sync_prev;
  logic          sclk_rise;
  logic          sclk_fall;
  logic          cs_fall;
  logic          cs_rise;
  logic [BW-1:0] rx_shift;
  logic [BW-1:0] tx_shift;
  logic [CW-1:0] bit_cnt;
  logic          load_next;

  // --------------------------------------------------------------------------
  // Pin synchroniser and edge detection
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync_a    <= '{sclk: 1'b0, mosi: 1'b0, cs: 1'b1};
      sync_b    <= '{sclk: 1'b0, mosi: 1'b0, cs: 1'b1};
      sync_prev <= '{sclk: 1'b0, mosi: 1'b0, cs: 1'b1};
    end else begin
      sync_a    <= spi;
      sync_b    <= sync_a;
      sync_prev <= sync_b;
    end
  end

  // sclk only counts while cs is low
  assign sclk_rise = sync_b.sclk && !sync_prev.sclk && !sync_b.cs;
  assign sclk_fall = !sync_b.sclk && sync_prev.sclk && !sync_b.cs;
  assign cs_fall   = !sync_b.cs && sync_prev.cs;
  assign cs_rise   = sync_b.cs && !sync_prev.cs;

  // --------------------------------------------------------------------------
  // Frame and bit control
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_begin   <= 1'b0;
      frame_end     <= 1'b0;
      in_frame      <= 1'b0;
      rx_byte_valid <= 1'b0;
      byte_done     <= 1'b0;
      bit_cnt       <= '0;
      load_next     <= 1'b0;
      tx_shift      <= '0;
    end else begin
      frame_begin   <= cs_fall;
      frame_end     <= cs_rise;
      rx_byte_valid <= 1'b0;
      byte_done     <= 1'b0;
      if (cs_fall) in_frame <= 1'b1;
      else if (cs_rise) in_frame <= 1'b0;

      if (frame_begin) begin
        // First byte of the frame goes straight onto miso
        bit_cnt   <= '0;
        load_next <= 1'b0;
        tx_shift  <= tx_byte;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + CW'(1);
        if (bit_cnt == CW'(BW - 1)) begin
          rx_byte_valid <= 1'b1;
          byte_done     <= 1'b1;
          load_next     <= 1'b1;
        end
      end else if (sclk_fall) begin
        if (load_next) begin
          tx_shift  <= tx_byte;
          load_next <= 1'b0;
        end else begin
          tx_shift <= {tx_shift[BW-2:0], 1'b0};
        end
      end
    end
  end

  // Receive shifter, MSB first
  always_ff @(posedge clk) begin
    if (sclk_rise) rx_shift <= {rx_shift[BW-2:0], sync_b.mosi};
  end

  assign rx_byte = rx_shift;
  assign miso    = tx_shift[BW-1];

  // Bytes complete only inside a frame, with cs still low
  a_done_in_frame: assert property (@(posedge clk) disable iff (rst)
    byte_done |-> (in_frame && !frame_end && !sync_b.cs));

endmodule

// ==== source/word_to_byte_splitter.sv ====
`include "spi_pu_macros.svh"

module word_to_byte_splitter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          word_valid,
  output logic                          word_ready,
  input  spi_pu_pkg::tx_word_t          word,
  input  logic                          byte_done,
  input  logic                          frame_begin,
  output logic [`SPI_PU_BYTE_WIDTH-1:0] tx_byte
);

  localparam int BW = `SPI_PU_BYTE_WIDTH;
  localparam int NB = `SPI_PU_DATA_WIDTH / BW;
  localparam int IW = $clog2(NB);

  logic [IW-1:0] byte_idx;
  logic [IW-1:0] cur_idx;

  // Byte index counts down from the MSB byte
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      byte_idx <= IW'(NB - 1);
    end else if (frame_begin) begin
      byte_idx <= IW'(NB - 1);
    end else if (byte_done) begin
      byte_idx <= byte_idx - IW'(1);
    end
  end

  // The driver loads during frame_begin, so present the MSB byte right away
  assign cur_idx = frame_begin ? IW'(NB - 1) : byte_idx;

  // Head of the drain bank is the current word
  // Zero bytes go out while nothing is queued
  assign tx_byte = word_valid ? word.data[cur_idx*BW +: BW] : '0;

  // Pop once the LSB byte has been taken
  assign word_ready = byte_done && (byte_idx == '0);

endmodule

// ==== source/byte_to_word_assembler.sv ====
`include "spi_pu_macros.svh"

module byte_to_word_assembler (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`SPI_PU_BYTE_WIDTH-1:0] rx_byte,
  input  logic                          rx_byte_valid,
  input  logic                          frame_end,
  output logic                          entry_valid,
  output spi_pu_pkg::rx_entry_t         entry
);

  localparam int BW = `SPI_PU_BYTE_WIDTH;
  localparam int DW = `SPI_PU_DATA_WIDTH;
  localparam int NB = DW / BW;
  localparam int IW = $clog2(NB);

  logic [DW-1:0] shift_word;
  logic [DW-1:0] next_word;
  logic [DW-1:0] pend_word;
  logic [IW-1:0] byte_cnt;
  logic          pend_valid;
  logic          word_done;

  assign next_word = {shift_word[DW-BW-1:0], rx_byte};
  assign word_done = rx_byte_valid && (byte_cnt == IW'(NB - 1));

  // A finished word waits here until the next word or the frame end
  // decides its last flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      byte_cnt    <= '0;
      pend_valid  <= 1'b0;
      entry_valid <= 1'b0;
    end else begin
      entry_valid <= 1'b0;
      if (frame_end) begin
        byte_cnt    <= '0;
        pend_valid  <= 1'b0;
        entry_valid <= pend_valid;
      end else if (rx_byte_valid) begin
        byte_cnt <= byte_cnt + IW'(1);
        if (word_done) begin
          pend_valid  <= 1'b1;
          entry_valid <= pend_valid;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_byte_valid) shift_word <= next_word;
    if (word_done) pend_word <= next_word;
    if (frame_end || word_done) begin
      entry.data <= pend_word;
      entry.last <= frame_end;
    end
  end

endmodule

// ==== source/spi_pu_slave.sv ====
`include "spi_pu_macros.svh"

module spi_pu_slave (
  input  logic                clk,
  input  logic                rst,
  input  spi_pu_pkg::wb_req_t wb_req,
  output spi_pu_pkg::wb_rsp_t wb_rsp,
  input  spi_pu_pkg::spi_in_t spi,
  output logic                miso,
  output logic                frame_start,
  output logic                frame_stop
);

  import spi_pu_pkg::*;

  logic       fill_bank;
  logic       last_q;
  logic       req_new;
  logic       is_data;
  logic       is_status;
  logic       wr_data;
  logic       rd_data;
  status_t    status;

  // Transmit banks
  tx_word_t   push_word;
  logic       a_in_valid;
  logic       a_in_ready;
  logic       a_out_valid;
  logic       a_out_ready;
  tx_word_t   a_out_data;
  logic [2:0] a_count;
  logic       b_in_valid;
  logic       b_in_ready;
  logic       b_out_valid;
  logic       b_out_ready;
  tx_word_t   b_out_data;
  logic [2:0] b_count;
  logic       fill_ready;
  logic [2:0] fill_count;
  logic [2:0] drain_count;
  logic       drain_valid;
  tx_word_t   drain_word;

  // Receive path
  logic       rx_entry_valid;
  rx_entry_t  rx_entry;
  logic       rx_out_valid;
  rx_entry_t  rx_out_data;
  logic [2:0] rx_count;

  // SPI core links
  logic [`SPI_PU_BYTE_WIDTH-1:0] tx_byte;
  logic [`SPI_PU_BYTE_WIDTH-1:0] rx_byte;
  logic       rx_byte_valid;
  logic       byte_done;
  logic       word_ready;
  logic       frame_begin;
  logic       frame_end;
  logic       in_frame;

  // --------------------------------------------------------------------------
  // Wishbone decode and response
  // --------------------------------------------------------------------------
  assign req_new   = wb_req.cyc && wb_req.stb && !wb_rsp.ack && !wb_rsp.err;
  assign is_data   = (wb_req.adr == 4'(`SPI_PU_ADR_DATA));
  assign is_status = (wb_req.adr == 4'(`SPI_PU_ADR_STATUS));
  assign wr_data   = req_new && wb_req.we && is_data;
  assign rd_data   = req_new && !wb_req.we && is_data;
  assign push_word = tx_word_t'(wb_req.dat);

  always_comb begin
    status             = '0;
    status.rsvd        = {last_q, {($bits(status.rsvd) - 1){1'b0}}};
    status.rx_count    = rx_count;
    status.fill_count  = fill_count;
    status.drain_count = drain_count;
    status.fill_bank   = fill_bank;
    status.in_frame    = in_frame;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_rsp <= '0;
      last_q <= 1'b0;
    end else begin
      wb_rsp.ack <= 1'b0;
      wb_rsp.err <= 1'b0;
      if (req_new) begin
        wb_rsp.dat <= '0;
        if (is_data && wb_req.we) begin
          wb_rsp.ack <= fill_ready;
          wb_rsp.err <= !fill_ready;
        end else if (is_data) begin
          wb_rsp.ack <= rx_out_valid;
          wb_rsp.err <= !rx_out_valid;
          if (rx_out_valid) begin
            wb_rsp.dat <= rx_out_data.data;
            last_q     <= rx_out_data.last;
          end
        end else if (is_status) begin
          // Status writes are accepted and ignored
          wb_rsp.ack <= 1'b1;
          if (!wb_req.we) wb_rsp.dat <= status;
        end else begin
          wb_rsp.err <= 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Ping-pong bank steering
  // --------------------------------------------------------------------------
  // fill_bank 0 means bank_a fills while bank_b drains
  assign a_in_valid  = wr_data && !fill_bank;
  assign b_in_valid  = wr_data && fill_bank;
  assign a_out_ready = word_ready && fill_bank;
  assign b_out_ready = word_ready && !fill_bank;
  assign fill_ready  = fill_bank ? b_in_ready : a_in_ready;
  assign fill_count  = fill_bank ? b_count : a_count;
  assign drain_count = fill_bank ? a_count : b_count;
  assign drain_valid = fill_bank ? a_out_valid : b_out_valid;
  assign drain_word  = fill_bank ? a_out_data : b_out_data;

  // Swap only between frames, once the drain side has run dry
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_bank <= 1'b0;
    end else if (frame_end && drain_count == 3'd0 && fill_count != 3'd0) begin
      fill_bank <= !fill_bank;
    end
  end

  word_buffer #(.payload_t(tx_word_t), .DEPTH(`SPI_PU_TX_DEPTH)) bank_a (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (a_in_valid),
    .in_ready  (a_in_ready),
    .in_data   (push_word),
    .out_valid (a_out_valid),
    .out_ready (a_out_ready),
    .out_data  (a_out_data),
    .flush     (1'b0),
    .count     (a_count)
  );

  word_buffer #(.payload_t(tx_word_t), .DEPTH(`SPI_PU_TX_DEPTH)) bank_b (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (b_in_valid),
    .in_ready  (b_in_ready),
    .in_data   (push_word),
    .out_valid (b_out_valid),
    .out_ready (b_out_ready),
    .out_data  (b_out_data),
    .flush     (1'b0),
    .count     (b_count)
  );

  // Words arriving while the queue is full are dropped
  word_buffer #(.payload_t(rx_entry_t), .DEPTH(`SPI_PU_RX_DEPTH)) rx_queue (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (rx_entry_valid),
    .in_ready  (),
    .in_data   (rx_entry),
    .out_valid (rx_out_valid),
    .out_ready (rd_data),
    .out_data  (rx_out_data),
    .flush     (1'b0),
    .count     (rx_count)
  );

  // --------------------------------------------------------------------------
  // SPI datapath
  // --------------------------------------------------------------------------
  spi_slave_driver u_driver (
    .clk           (clk),
    .rst           (rst),
    .spi           (spi),
    .tx_byte       (tx_byte),
    .miso          (miso),
    .rx_byte       (rx_byte),
    .rx_byte_valid (rx_byte_valid),
    .byte_done     (byte_done),
    .frame_begin   (frame_begin),
    .frame_end     (frame_end),
    .in_frame      (in_frame)
  );

  word_to_byte_splitter u_splitter (
    .clk         (clk),
    .rst         (rst),
    .word_valid  (drain_valid),
    .word_ready  (word_ready),
    .word        (drain_word),
    .byte_done   (byte_done),
    .frame_begin (frame_begin),
    .tx_byte     (tx_byte)
  );

  byte_to_word_assembler u_assembler (
    .clk           (clk),
    .rst           (rst),
    .rx_byte       (rx_byte),
    .rx_byte_valid (rx_byte_valid),
    .frame_end     (frame_end),
    .entry_valid   (rx_entry_valid),
    .entry         (rx_entry)
  );

  // Frame pulses come straight from the driver's registered edge detect
  assign frame_start = frame_begin;
  assign frame_stop  = frame_end;

endmodule

// ==== testbench/spi_pu_slave_tb.sv ====
`include "spi_pu_macros.svh"

module spi_pu_slave_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import spi_pu_pkg::*;

  // Seven SPI frames at 64 clocks per byte come to about 3400 cycles
  // and the bus cycles add a few hundred more
  localparam int         MAX_CYCLES = 6000;
  localparam logic [3:0] ADR_DATA   = 4'(`SPI_PU_ADR_DATA);
  localparam logic [3:0] ADR_STATUS = 4'(`SPI_PU_ADR_STATUS);

  logic       clk;
  logic       rst;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  spi_in_t    spi;
  logic       miso;
  logic       frame_start;
  logic       frame_stop;

  integer     seed = 32'h5339646d;
  int         cycles = 0;
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;
  int         test_errors = 0;
  string      test_name;
  int         start_pulses = 0;
  int         stop_pulses = 0;
  int         frames_run = 0;
  logic [7:0] mosi_bytes [16];
  logic [7:0] miso_bytes [16];

  spi_pu_slave UUT (
    .clk         (clk),
    .rst         (rst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .spi         (spi),
    .miso        (miso),
    .frame_start (frame_start),
    .frame_stop  (frame_stop)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog plus frame pulse counters
  always @(posedge clk) begin
    cycles++;
    if (frame_start) start_pulses++;
    if (frame_stop) stop_pulses++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // -------------------------------------------------------------------------
  // Checking and reporting
  // -------------------------------------------------------------------------
  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error in %s: %s", test_name, what);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests++;
  endtask

  task automatic end_test();
    $display("%-18s %s", test_name, (errors == test_errors) ? "ok" : "FAILED");
  endtask

  // -------------------------------------------------------------------------
  // Bus and SPI master
  // -------------------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // Request held until the slave answers with ack or err
  task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic ack, output logic err);
    @(posedge clk);
    #2;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_rsp.ack && !wb_rsp.err);
    rdat = wb_rsp.dat;
    ack  = wb_rsp.ack;
    err  = wb_rsp.err;
    #1;
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat,
                          output logic ack, output logic err);
    logic [31:0] ignored;
    bus_cycle(1'b1, adr, wdat, ignored, ack, err);
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat,
                         output logic ack, output logic err);
    bus_cycle(1'b0, adr, '0, rdat, ack, err);
  endtask

  task automatic read_status(output status_t st);
    logic [31:0] dat;
    logic        ack;
    logic        err;
    wb_read(ADR_STATUS, dat, ack, err);
    check_true(ack && !err, "STATUS read was not acknowledged");
    st = status_t'(dat);
  endtask

  task automatic push_word(input logic [31:0] w);
    logic ack;
    logic err;
    wb_write(ADR_DATA, w, ack, err);
    check_true(ack && !err, "DATA write into a bank with free space was not acknowledged");
  endtask

  task automatic drain_rx_queue();
    logic [31:0] dat;
    logic        ack;
    logic        err;
    for (int i = 0; i < 8; i++) begin
      wb_read(ADR_DATA, dat, ack, err);
      if (err) break;
    end
  endtask

  // Mode 0, MSB first, sclk period of 8 clocks; miso is taken just before each rising sclk
  task automatic spi_frame(input int nbytes);
    logic [7:0] cap;
    @(posedge clk);
    #2;
    spi.cs = 1'b0;
    wait_cycles(8);
    for (int i = 0; i < nbytes; i++) begin
      for (int b = 7; b >= 0; b--) begin
        spi.mosi = mosi_bytes[i][b];
        wait_cycles(4);
        cap[b]   = miso;
        spi.sclk = 1'b1;
        wait_cycles(4);
        spi.sclk = 1'b0;
      end
      miso_bytes[i] = cap;
    end
    wait_cycles(4);
    spi.cs = 1'b1;
    wait_cycles(8);
    frames_run++;
  endtask

  // -------------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------------
  task automatic test_reset_state();
    status_t     st;
    logic [31:0] dat;
    logic        ack;
    logic        err;
    start_test("reset_state");
    read_status(st);
    check_value("STATUS", 32'h0, st);
    wb_read(ADR_DATA, dat, ack, err);
    check_true(err && !ack, "DATA read on an empty receive queue was not answered with err");
    check_value("DATA on err", 32'h0, dat);
    check_value("frame_start pulses", 32'd0, start_pulses);
    check_value("frame_stop pulses", 32'd0, stop_pulses);
    end_test();
  endtask

  task automatic test_transmit_bank();
    logic [31:0] w [2];
    logic [31:0] exp;
    status_t     st;
    start_test("transmit_bank");
    w[0] = $random(seed);
    w[1] = $random(seed);
    push_word(w[0]);
    push_word(w[1]);
    for (int i = 0; i < 8; i++) mosi_bytes[i] = 8'($random(seed));
    // Drain bank still empty, so only zeros go out
    spi_frame(8);
    for (int i = 0; i < 8; i++) check_value($sformatf("frame 1 byte %0d", i), 0, miso_bytes[i]);
    read_status(st);
    check_value("fill_bank after swap", 1, st.fill_bank);
    check_value("drain_count after swap", 2, st.drain_count);
    check_value("fill_count after swap", 0, st.fill_count);
    spi_frame(8);
    for (int i = 0; i < 8; i++) begin
      exp = w[i / 4] >> (8 * (3 - i % 4));
      check_value($sformatf("frame 2 byte %0d", i), exp[7:0], miso_bytes[i]);
    end
    read_status(st);
    check_value("drain_count after frame 2", 0, st.drain_count);
    check_value("fill_bank after frame 2", 1, st.fill_bank);
    end_test();
  endtask

  task automatic test_receive_assembly();
    logic [31:0] dat;
    logic        ack;
    logic        err;
    status_t     st;
    start_test("receive_assembly");
    drain_rx_queue();
    for (int i = 0; i < 10; i++) mosi_bytes[i] = 8'($random(seed));
    spi_frame(10);
    for (int k = 0; k < 2; k++) begin
      wb_read(ADR_DATA, dat, ack, err);
      check_true(ack && !err, "DATA read of a received word was not acknowledged");
      check_value($sformatf("word %0d", k), {mosi_bytes[4*k], mosi_bytes[4*k+1],
                  mosi_bytes[4*k+2], mosi_bytes[4*k+3]}, dat);
      read_status(st);
      check_value($sformatf("last flag of word %0d", k), k, st[31]);
    end
    // The two trailing bytes never made a word
    wb_read(ADR_DATA, dat, ack, err);
    check_true(err && !ack, "third DATA read returned data from a partial word");
    end_test();
  endtask

  task automatic test_ping_pong();
    logic [31:0] a [2];
    logic [31:0] b [2];
    logic [31:0] exp;
    logic        fb;
    status_t     st;
    start_test("ping_pong");
    for (int i = 0; i < 2; i++) begin
      a[i] = $random(seed);
      b[i] = $random(seed);
    end
    read_status(st);
    fb = st.fill_bank;
    push_word(a[0]);
    push_word(a[1]);
    for (int i = 0; i < 8; i++) mosi_bytes[i] = 8'h00;
    spi_frame(4);
    for (int i = 0; i < 4; i++) check_value($sformatf("idle byte %0d", i), 0, miso_bytes[i]);
    read_status(st);
    check_value("fill_bank after first swap", !fb, st.fill_bank);
    // Writes during the frame must land in the fill bank only
    fork
      spi_frame(8);
      begin
        wait_cycles(20);
        push_word(b[0]);
        push_word(b[1]);
        read_status(st);
        check_value("fill_count in frame", 2, st.fill_count);
        check_value("drain_count in frame", 2, st.drain_count);
        check_value("in_frame", 1, st.in_frame);
        check_value("fill_bank in frame", !fb, st.fill_bank);
      end
    join
    for (int i = 0; i < 8; i++) begin
      exp = a[i / 4] >> (8 * (3 - i % 4));
      check_value($sformatf("drain byte %0d", i), exp[7:0], miso_bytes[i]);
    end
    read_status(st);
    check_value("fill_bank after second swap", fb, st.fill_bank);
    check_value("drain_count after second swap", 2, st.drain_count);
    check_value("fill_count after second swap", 0, st.fill_count);
    spi_frame(8);
    for (int i = 0; i < 8; i++) begin
      exp = b[i / 4] >> (8 * (3 - i % 4));
      check_value($sformatf("swapped byte %0d", i), exp[7:0], miso_bytes[i]);
    end
    end_test();
  endtask

  task automatic test_overflow();
    logic    ack;
    logic    err;
    int      s0;
    int      p0;
    status_t st;
    start_test("overflow");
    for (int i = 0; i < 4; i++) push_word($random(seed));
    wb_write(ADR_DATA, $random(seed), ack, err);
    check_true(err && !ack, "fifth DATA write into a full bank was not answered with err");
    read_status(st);
    check_value("fill_count when full", 4, st.fill_count);
    s0 = start_pulses;
    p0 = stop_pulses;
    spi_frame(4);
    check_value("frame_start pulses in frame", 1, start_pulses - s0);
    check_value("frame_stop pulses in frame", 1, stop_pulses - p0);
    check_value("frame_start pulses overall", frames_run, start_pulses);
    check_value("frame_stop pulses overall", frames_run, stop_pulses);
    read_status(st);
    check_value("fill_count after swap", 0, st.fill_count);
    check_value("drain_count after swap", 4, st.drain_count);
    push_word($random(seed));
    end_test();
  endtask

  initial begin
    wb_req = '0;
    spi    = '{sclk: 1'b0, mosi: 1'b0, cs: 1'b1};
    rst    = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    test_reset_state();
    test_transmit_bank();
    test_receive_assembly();
    test_ping_pong();
    test_overflow();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
source/spi_pu_pkg.sv
source/word_buffer.sv
source/spi_slave_driver.sv
source/word_to_byte_splitter.sv
source/byte_to_word_assembler.sv
source/spi_pu_slave.sv
testbench/spi_pu_slave_tb.sv

// ==== Makefile ====
TOP = spi_pu_slave_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
